//--- riscv_core.f
+incdir+tb
common/riscv_pkg.sv
execute/alu.sv
decode/reg_file.sv
fetch/fetch_unit.sv
decode/decode_stage.sv
execute/execute_stage.sv
src/writeback_stage.sv
src/forward_unit.sv
src/riscv_core.sv
tb/riscv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f riscv_core.f --top-module riscv_core_tb \
  -Mdir obj_dir -o riscv_core_sim
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

./obj_dir/riscv_core_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0

//--- tb/tb_iss.svh
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// Instruction-set model, run on the same program image as the DUT

logic [31:0] xr [0:31];
logic [31:0] model_mem [logic [31:0]];
logic [31:0] exp_st_addr [$];
logic [31:0] exp_st_data [$];
logic [31:0] exp_csr [$];
logic [31:0] model_csr;

function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    default: return a >= b;
  endcase
endfunction

task automatic run_model();
  logic [31:0] pc, nxt, ins, a, b, res, addr, v;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [2:0]  f3;
  logic        wr;
  int          steps;
  for (int i = 0; i < 32; i++) begin
    xr[i] = 32'd0;
  end
  model_mem.delete();
  exp_st_addr.delete();
  exp_st_data.delete();
  exp_csr.delete();
  model_csr = 32'd0;
  pc = PC_RESET;
  steps = 0;
  ins = fetch_word(pc);
  while (ins != HALT_INSTR && steps <= prog_len) begin
    a = xr[ins[19:15]];
    b = xr[ins[24:20]];
    f3 = ins[14:12];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    nxt = pc + 32'd4;
    wr = 1'b1;
    res = 32'd0;
    case (ins[6:0])
      7'h37: res = imm_u;
      7'h17: res = pc + imm_u;
      7'h6f: begin
        res = pc + 32'd4;
        nxt = pc + imm_j;
      end
      7'h67: begin
        res = pc + 32'd4;
        nxt = (a + imm_i) & ~32'd1;
      end
      7'h03: res = model_mem.exists(a + imm_i) ? model_mem[a + imm_i] : mem_fill(a + imm_i);
      7'h13: res = alu_model(f3, ins[30] && f3 == 3'd5, a, imm_i);
      7'h33: res = alu_model(f3, ins[30], a, b);
      7'h63: begin
        wr = 1'b0;
        if (branch_taken(f3, a, b)) begin
          nxt = pc + imm_b;
        end
      end
      7'h23: begin
        wr = 1'b0;
        addr = a + imm_s;
        model_mem[addr] = b;
        exp_st_addr.push_back(addr);
        exp_st_data.push_back(b);
      end
      default: begin
        // CSRRW / CSRRWI, rd is always x0
        wr = 1'b0;
        v = f3[2] ? {27'd0, ins[19:15]} : a;
        if (v != model_csr) begin
          exp_csr.push_back(v);
        end
        model_csr = v;
      end
    endcase
    if (wr && ins[11:7] != 5'd0) begin
      xr[ins[11:7]] = res;
    end
    pc = nxt;
    steps++;
    ins = fetch_word(pc);
  end
  if (ins != HALT_INSTR) begin
    report_failure("model never reached the final self-jump");
  end
endtask

`endif

//--- tb/riscv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_core_tb;

  localparam logic [31:0] PC_RESET   = 32'h0000_2000;
  localparam logic [31:0] HALT_INSTR = 32'h0000_006f;
  localparam logic [31:0] NOP_WORD   = 32'h0000_0013;
  localparam int          N_PROGRAMS = 6;
  localparam int          TIMEOUT    = 5000;

  logic        clk;
  logic        rst_i;
  logic [31:0] icache_addr_o, icache_dout_i;
  logic [31:0] dcache_addr_o, dcache_din_o, dcache_dout_i;
  logic [3:0]  dcache_we_o;
  logic [31:0] csr_o;

  logic [31:0] prog [0:511];
  logic [31:0] dmem [logic [31:0]];
  int          prog_len;
  logic [31:0] halt_pc;
  logic [31:0] rng = 32'd68;
  int          error_count = 0;
  int          stores_seen;
  int          csr_idx;
  logic [31:0] csr_seen;

  riscv_core #(.PC_RESET(PC_RESET)) dut (
    .clk          (clk),
    .rst_i        (rst_i),
    .icache_addr_o(icache_addr_o),
    .icache_dout_i(icache_dout_i),
    .dcache_addr_o(dcache_addr_o),
    .dcache_din_o (dcache_din_o),
    .dcache_we_o  (dcache_we_o),
    .dcache_dout_i(dcache_dout_i),
    .csr_o        (csr_o)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic report_failure(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] xorshift();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  // Untouched data words depend on the full address
  function automatic logic [31:0] mem_fill(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] a);
    logic [31:0] idx;
    idx = (a - PC_RESET) >> 2;
    if (a >= PC_RESET && idx < prog_len) begin
      return prog[idx[8:0]];
    end
    return NOP_WORD;
  endfunction

  `include "tb_iss.svh"

  ////////////////////
  // Encoders
  ////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  ////////////////////
  // Program generation
  ////////////////////

  task automatic emit(input logic [31:0] w);
    prog[9'(prog_len)] = w;
    prog_len++;
  endtask

  // Arithmetic, stores or CSR writes; also used in shadows of jumps
  task automatic emit_simple();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [11:0] imm;
    r = xorshift();
    f3 = r[14:12];
    if (r[18:16] == 3'd0) begin
      emit(enc_s(12'h100 + {4'd0, r[27:22], 2'b00}, 5'(r[11:8]), 5'd0));
    end else if (r[18:16] == 3'd1) begin
      emit(enc_i(12'h340, r[20] ? 5'(r[26:22]) : 5'(r[7:4]), r[20] ? 3'd5 : 3'd1, 5'd0,
                 7'h73));
    end else if (r[16]) begin
      emit(enc_r((f3 == 3'd0 || f3 == 3'd5) && r[17] ? 7'h20 : 7'h00, 5'(r[11:8]),
                 5'(r[7:4]), f3, 5'(1 + r[3:0] % 15)));
    end else begin
      imm = r[31:20];
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm[11:5] = (f3 == 3'd5 && r[17]) ? 7'h20 : 7'h00;
      end
      emit(enc_i(imm, 5'(r[7:4]), f3, 5'(1 + r[3:0] % 15), 7'h13));
    end
  endtask

  task automatic emit_block();
    logic [31:0] r;
    logic [4:0]  rd, rb, rs;
    int          skip;
    int          k;
    r = xorshift();
    rd = 5'(1 + r[7:4] % 15);
    rb = 5'(1 + r[11:8] % 15);
    rs = 5'(r[15:12]);
    skip = int'(r[17:16]);
    case (r[20:18])
      3'd0, 3'd1: emit_simple();
      3'd2: emit({r[31:12], rd, r[21] ? 7'h37 : 7'h17});
      3'd3: begin
        // Address built just before the load, then an immediate user
        emit(enc_i(12'h100, 5'd0, 3'd0, rb, 7'h13));
        emit(enc_i({6'd0, r[25:22], 2'b00}, rb, 3'd2, rd, 7'h03));
        if (r[26]) begin
          emit(enc_s(12'h100 + {4'd0, r[31:26], 2'b00}, rd, 5'd0));
        end else begin
          emit(enc_r(7'h00, rs, rd, 3'd0, 5'(1 + r[31:28] % 15)));
        end
      end
      3'd4: begin
        k = int'(r[25:22] % 6);
        emit(enc_b(13'((skip + 1) * 4), rs, 5'(r[31:28]), (k < 2) ? 3'(k) : 3'(k + 2)));
        repeat (skip) emit_simple();
      end
      3'd5: begin
        emit(enc_j(21'((skip + 2) * 4), r[21] ? rd : 5'd0));
        repeat (skip + 1) emit_simple();
      end
      3'd6: begin
        emit({20'd0, rb, 7'h17});
        emit(enc_i(12'((skip + 2) * 4) | {11'd0, r[21]}, rb, 3'd0, rd, 7'h67));
        repeat (skip) emit_simple();
      end
      default: begin
        emit(enc_s(12'h100 + {4'd0, r[27:22], 2'b00}, rs, 5'd0));
        emit(enc_i(12'h100 + {4'd0, r[27:22], 2'b00}, 5'd0, 3'd2, rd, 7'h03));
      end
    endcase
  endtask

  task automatic gen_program();
    logic [31:0] r;
    prog_len = 0;
    for (int i = 1; i < 16; i++) begin
      r = xorshift();
      emit({r[31:12], 5'(i), 7'h37});
      r = xorshift();
      emit(enc_i(r[11:0], 5'(i), 3'd0, 5'(i), 7'h13));
    end
    repeat (40) emit_block();
    // Register dump, then the self-jump
    for (int i = 1; i < 16; i++) begin
      emit(enc_s(12'(12'h200 + 4 * i), 5'(i), 5'd0));
    end
    halt_pc = PC_RESET + 32'(4 * prog_len);
    emit(HALT_INSTR);
  endtask

  ////////////////////
  // Memories and monitors
  ////////////////////

  always @(posedge clk) begin
    logic [31:0] ia, da, wd;
    logic [3:0]  we;
    ia = icache_addr_o;
    da = dcache_addr_o;
    wd = dcache_din_o;
    we = dcache_we_o;
    if (!rst_i && we != 4'h0) begin
      if (stores_seen >= exp_st_addr.size()) begin
        report_failure("DUT made a store the model did not make");
      end
      check_equal({28'd0, we}, 32'hf, "store byte enables");
      check_equal(da, exp_st_addr[stores_seen], "store address");
      check_equal(wd, exp_st_data[stores_seen], "store data");
      stores_seen++;
      dmem[da] = wd;
    end
    if (!rst_i && csr_o != csr_seen) begin
      if (csr_idx >= exp_csr.size()) begin
        report_failure("csr_o changed more often than the model's CSR writes");
      end
      check_equal(csr_o, exp_csr[csr_idx], "csr_o change");
      csr_idx++;
      csr_seen = csr_o;
    end
    #1;
    icache_dout_i = fetch_word(ia);
    dcache_dout_i = dmem.exists(da) ? dmem[da] : mem_fill(da);
  end

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (!(stores_seen == exp_st_addr.size() && icache_addr_o == halt_pc)) begin
      @(negedge clk);
      cycles++;
      if (icache_addr_o > halt_pc + 32'd4 || icache_addr_o < PC_RESET) begin
        report_failure("fetch ran outside the program without reaching the self-jump");
      end
      if (cycles > TIMEOUT) begin
        report_failure("program did not reach its final self-jump in time");
      end
    end
  endtask

  initial begin
    rst_i = 1'b1;
    icache_dout_i = NOP_WORD;
    dcache_dout_i = 32'd0;
    prog_len = 0;
    stores_seen = 0;
    csr_idx = 0;
    csr_seen = 32'd0;
    for (int p = 0; p < N_PROGRAMS; p++) begin
      @(posedge clk);
      #1 rst_i = 1'b1;
      gen_program();
      run_model();
      dmem.delete();
      stores_seen = 0;
      csr_idx = 0;
      csr_seen = 32'd0;
      repeat (10) @(posedge clk);
      #1 rst_i = 1'b0;
      check_equal(icache_addr_o, PC_RESET, "first fetch address");
      check_equal({28'd0, dcache_we_o}, 32'd0, "store enable after reset");
      check_equal(csr_o, 32'd0, "csr_o after reset");
      wait_for_halt();
      // Let anything still in flight show up
      repeat (8) @(negedge clk);
      check_equal(32'(csr_idx), 32'(exp_csr.size()), "csr change count");
      check_equal(csr_o, model_csr, "final csr_o");
      $display("Program %0d done: %0d stores, %0d CSR changes", p, stores_seen, csr_idx);
    end
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/riscv_core.sv
`timescale 1ns/1ns
`default_nettype none

module riscv_core #(
  parameter logic [riscv_pkg::XLEN-1:0] PC_RESET = 32'h0000_2000
) (
  input  logic                        clk,
  input  logic                        rst_i,
  output logic [riscv_pkg::XLEN-1:0]  icache_addr_o,
  input  logic [riscv_pkg::XLEN-1:0]  icache_dout_i,
  output logic [riscv_pkg::XLEN-1:0]  dcache_addr_o,
  output logic [riscv_pkg::XLEN-1:0]  dcache_din_o,
  output logic [3:0]                  dcache_we_o,
  input  logic [riscv_pkg::XLEN-1:0]  dcache_dout_i,
  output logic [riscv_pkg::XLEN-1:0]  csr_o
);
  import riscv_pkg::*;

  // Fetch to decode
  logic [XLEN-1:0] f_instr, f_pc;
  logic            jal;
  logic [XLEN-1:0] jal_target;
  logic            redirect;
  logic [XLEN-1:0] redirect_target;

  // Decode to execute
  ctrl_t             ex_ctrl;
  logic [XLEN-1:0]   ex_rs1_val, ex_rs2_val, ex_imm, ex_pc;
  logic [REG_AW-1:0] ex_rd, ex_rs1, ex_rs2;
  logic [7:0]        ex_funct;
  logic [REG_AW-1:0] id_rs1, id_rs2;
  logic [XLEN-1:0]   ex_result;

  // Execute to writeback
  ctrl_t             wb_ctrl;
  logic [XLEN-1:0]   wb_alu, wb_pc4;
  logic [REG_AW-1:0] wb_rd;

  // Writeback to register file and forwarding
  logic [REG_AW-1:0] rf_waddr;
  logic [XLEN-1:0]   rf_wdata;
  logic              rf_we;

  logic [1:0] fwd_a_sel, fwd_b_sel;
  logic       fwd_br_a, fwd_br_b;

  fetch_unit #(.PC_RESET(PC_RESET)) u_fetch (
    .clk              (clk),
    .rst_i            (rst_i),
    .jal_i            (jal),
    .jal_target_i     (jal_target),
    .redirect_i       (redirect),
    .redirect_target_i(redirect_target),
    .icache_addr_o    (icache_addr_o),
    .icache_dout_i    (icache_dout_i),
    .instr_o          (f_instr),
    .pc_o             (f_pc)
  );

  decode_stage u_decode (
    .clk         (clk),
    .rst_i       (rst_i),
    .instr_i     (f_instr),
    .pc_i        (f_pc),
    .kill_i      (redirect),
    .wb_addr_i   (rf_waddr),
    .wb_data_i   (rf_wdata),
    .wb_we_i     (rf_we),
    .exe_result_i(ex_result),
    .fwd_a_sel_i (fwd_a_sel),
    .fwd_b_sel_i (fwd_b_sel),
    .jal_o       (jal),
    .jal_target_o(jal_target),
    .ctrl_o      (ex_ctrl),
    .rs1_val_o   (ex_rs1_val),
    .rs2_val_o   (ex_rs2_val),
    .imm_o       (ex_imm),
    .pc_o        (ex_pc),
    .funct_o     (ex_funct),
    .rd_o        (ex_rd),
    .rs1_o       (ex_rs1),
    .rs2_o       (ex_rs2),
    .id_rs1_o    (id_rs1),
    .id_rs2_o    (id_rs2)
  );

  execute_stage u_execute (
    .clk              (clk),
    .rst_i            (rst_i),
    .ctrl_i           (ex_ctrl),
    .rs1_val_i        (ex_rs1_val),
    .rs2_val_i        (ex_rs2_val),
    .imm_i            (ex_imm),
    .pc_i             (ex_pc),
    .rd_i             (ex_rd),
    .instr_funct_i    (ex_funct),
    .fwd_br_a_i       (fwd_br_a),
    .fwd_br_b_i       (fwd_br_b),
    .wb_result_i      (rf_wdata),
    .redirect_o       (redirect),
    .redirect_target_o(redirect_target),
    .result_o         (ex_result),
    .dcache_addr_o    (dcache_addr_o),
    .dcache_din_o     (dcache_din_o),
    .dcache_we_o      (dcache_we_o),
    .csr_o            (csr_o),
    .wb_ctrl_o        (wb_ctrl),
    .wb_result_o      (wb_alu),
    .wb_pc4_o         (wb_pc4),
    .wb_rd_o          (wb_rd)
  );

  writeback_stage u_writeback (
    .ctrl_i       (wb_ctrl),
    .result_i     (wb_alu),
    .pc4_i        (wb_pc4),
    .rd_i         (wb_rd),
    .dcache_dout_i(dcache_dout_i),
    .rf_waddr_o   (rf_waddr),
    .rf_wdata_o   (rf_wdata),
    .rf_we_o      (rf_we)
  );

  forward_unit u_forward (
    .id_rs1_i    (id_rs1),
    .id_rs2_i    (id_rs2),
    .ex_rs1_i    (ex_rs1),
    .ex_rs2_i    (ex_rs2),
    .ex_rd_i     (ex_rd),
    .ex_we_i     (ex_ctrl.reg_we),
    .ex_is_load_i(ex_ctrl.wb_sel == WB_MEM),
    .wb_rd_i     (rf_waddr),
    .wb_we_i     (rf_we),
    .fwd_a_sel_o (fwd_a_sel),
    .fwd_b_sel_o (fwd_b_sel),
    .fwd_br_a_o  (fwd_br_a),
    .fwd_br_b_o  (fwd_br_b)
  );

endmodule

`default_nettype wire

//--- src/forward_unit.sv
`timescale 1ns/1ns
`default_nettype none

module forward_unit (
  input  logic [riscv_pkg::REG_AW-1:0] id_rs1_i,
  input  logic [riscv_pkg::REG_AW-1:0] id_rs2_i,
  input  logic [riscv_pkg::REG_AW-1:0] ex_rs1_i,
  input  logic [riscv_pkg::REG_AW-1:0] ex_rs2_i,
  input  logic [riscv_pkg::REG_AW-1:0] ex_rd_i,
  input  logic                         ex_we_i,
  input  logic                         ex_is_load_i,
  input  logic [riscv_pkg::REG_AW-1:0] wb_rd_i,
  input  logic                         wb_we_i,
  output logic [1:0]                   fwd_a_sel_o,
  output logic [1:0]                   fwd_b_sel_o,
  output logic                         fwd_br_a_o,
  output logic                         fwd_br_b_o
);
  import riscv_pkg::*;

  // 0 register file, 1 execute, 2 writeback
  function automatic logic [1:0] id_sel(input logic [REG_AW-1:0] rs);
    if (rs == '0) begin
      return 2'd0;
    end
    // Load data is not ready in execute
    if (ex_we_i && !ex_is_load_i && ex_rd_i == rs) begin
      return 2'd1;
    end
    if (wb_we_i && wb_rd_i == rs) begin
      return 2'd2;
    end
    return 2'd0;
  endfunction

  assign fwd_a_sel_o = id_sel(id_rs1_i);
  assign fwd_b_sel_o = id_sel(id_rs2_i);

  // wb_we_i already excludes x0
  assign fwd_br_a_o = wb_we_i && (wb_rd_i == ex_rs1_i);
  assign fwd_br_b_o = wb_we_i && (wb_rd_i == ex_rs2_i);

endmodule

`default_nettype wire

//--- src/writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
  input  riscv_pkg::ctrl_t             ctrl_i,
  input  logic [riscv_pkg::XLEN-1:0]   result_i,
  input  logic [riscv_pkg::XLEN-1:0]   pc4_i,
  input  logic [riscv_pkg::REG_AW-1:0] rd_i,
  input  logic [riscv_pkg::XLEN-1:0]   dcache_dout_i,
  output logic [riscv_pkg::REG_AW-1:0] rf_waddr_o,
  output logic [riscv_pkg::XLEN-1:0]   rf_wdata_o,
  output logic                         rf_we_o
);
  import riscv_pkg::*;

  // Load data shows up this cycle
  assign rf_wdata_o = (ctrl_i.wb_sel == WB_MEM) ? dcache_dout_i :
                      (ctrl_i.wb_sel == WB_PC4) ? pc4_i         : result_i;

  assign rf_waddr_o = rd_i;
  assign rf_we_o    = ctrl_i.reg_we && (rd_i != '0);

endmodule

`default_nettype wire

//--- execute/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
  input  logic                         clk,
  input  logic                         rst_i,
  input  riscv_pkg::ctrl_t             ctrl_i,
  input  logic [riscv_pkg::XLEN-1:0]   rs1_val_i,
  input  logic [riscv_pkg::XLEN-1:0]   rs2_val_i,
  input  logic [riscv_pkg::XLEN-1:0]   imm_i,
  input  logic [riscv_pkg::XLEN-1:0]   pc_i,
  input  logic [riscv_pkg::REG_AW-1:0] rd_i,
  input  logic [7:0]                   instr_funct_i,
  input  logic                         fwd_br_a_i,
  input  logic                         fwd_br_b_i,
  input  logic [riscv_pkg::XLEN-1:0]   wb_result_i,
  output logic                         redirect_o,
  output logic [riscv_pkg::XLEN-1:0]   redirect_target_o,
  output logic [riscv_pkg::XLEN-1:0]   result_o,
  output logic [riscv_pkg::XLEN-1:0]   dcache_addr_o,
  output logic [riscv_pkg::XLEN-1:0]   dcache_din_o,
  output logic [3:0]                   dcache_we_o,
  output logic [riscv_pkg::XLEN-1:0]   csr_o,
  output riscv_pkg::ctrl_t             wb_ctrl_o,
  output logic [riscv_pkg::XLEN-1:0]   wb_result_o,
  output logic [riscv_pkg::XLEN-1:0]   wb_pc4_o,
  output logic [riscv_pkg::REG_AW-1:0] wb_rd_o
);
  import riscv_pkg::*;

  logic [2:0]      funct3;
  logic [XLEN-1:0] op_a, op_b, alu_a, alu_b, alu_res;
  logic            br_eq, br_lt, br_ltu, br_taken;

  assign funct3 = instr_funct_i[7:5];

  // Late fix for operands decode could not see, e.g. load data
  assign op_a = fwd_br_a_i ? wb_result_i : rs1_val_i;
  assign op_b = fwd_br_b_i ? wb_result_i : rs2_val_i;

  assign alu_a = ctrl_i.a_sel_pc  ? pc_i  : op_a;
  assign alu_b = ctrl_i.b_sel_imm ? imm_i : op_b;

  alu u_alu (
    .a_i     (alu_a),
    .b_i     (alu_b),
    .op_i    (ctrl_i.alu_op),
    .result_o(alu_res)
  );

  assign result_o = alu_res;

  ////////////////////
  // Branch resolve
  ////////////////////

  assign br_eq  = (op_a == op_b);
  assign br_lt  = ($signed(op_a) < $signed(op_b));
  assign br_ltu = (op_a < op_b);

  always_comb begin
    case (funct3)
      3'b000: br_taken = br_eq;
      3'b001: br_taken = !br_eq;
      3'b100: br_taken = br_lt;
      3'b101: br_taken = !br_lt;
      3'b110: br_taken = br_ltu;
      3'b111: br_taken = !br_ltu;
      default: br_taken = 1'b0;
    endcase
  end

  assign redirect_o        = (ctrl_i.is_branch && br_taken) || ctrl_i.is_jalr;
  assign redirect_target_o = {alu_res[XLEN-1:1], alu_res[0] & !ctrl_i.is_jalr};

  // Word stores only
  assign dcache_addr_o = alu_res;
  assign dcache_din_o  = op_b;
  assign dcache_we_o   = {4{ctrl_i.mem_we}};

  // CSRRWI when funct3 bit 2 is set
  always_ff @(posedge clk) begin
    if (rst_i) begin
      csr_o <= '0;
    end else if (ctrl_i.is_csr) begin
      csr_o <= funct3[2] ? {{(XLEN-5){1'b0}}, instr_funct_i[4:0]} : op_a;
    end
  end

  ////////////////////
  // Into writeback
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wb_ctrl_o <= '0;
    end else begin
      wb_ctrl_o <= ctrl_i;
    end
  end

  always_ff @(posedge clk) begin
    wb_result_o <= alu_res;
    wb_pc4_o    <= pc_i + 32'd4;
    wb_rd_o     <= rd_i;
  end

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic [riscv_pkg::XLEN-1:0]   instr_i,
  input  logic [riscv_pkg::XLEN-1:0]   pc_i,
  input  logic                         kill_i,
  input  logic [riscv_pkg::REG_AW-1:0] wb_addr_i,
  input  logic [riscv_pkg::XLEN-1:0]   wb_data_i,
  input  logic                         wb_we_i,
  input  logic [riscv_pkg::XLEN-1:0]   exe_result_i,
  input  logic [1:0]                   fwd_a_sel_i,
  input  logic [1:0]                   fwd_b_sel_i,
  output logic                         jal_o,
  output logic [riscv_pkg::XLEN-1:0]   jal_target_o,
  output riscv_pkg::ctrl_t             ctrl_o,
  output logic [riscv_pkg::XLEN-1:0]   rs1_val_o,
  output logic [riscv_pkg::XLEN-1:0]   rs2_val_o,
  output logic [riscv_pkg::XLEN-1:0]   imm_o,
  output logic [riscv_pkg::XLEN-1:0]   pc_o,
  output logic [7:0]                   funct_o,
  output logic [riscv_pkg::REG_AW-1:0] rd_o,
  output logic [riscv_pkg::REG_AW-1:0] rs1_o,
  output logic [riscv_pkg::REG_AW-1:0] rs2_o,
  output logic [riscv_pkg::REG_AW-1:0] id_rs1_o,
  output logic [riscv_pkg::REG_AW-1:0] id_rs2_o
);
  import riscv_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  alu_op_e         arith_op;
  imm_sel_e        imm_sel;
  ctrl_t           ctrl;
  logic [XLEN-1:0] imm, rf_a, rf_b, op_a, op_b;

  assign opcode   = opcode_e'(instr_i[6:0]);
  assign funct3   = instr_i[14:12];
  assign id_rs1_o = instr_i[19:15];
  assign id_rs2_o = instr_i[24:20];

  reg_file u_rf (
    .clk      (clk),
    .rst_i    (rst_i),
    .raddr_a_i(id_rs1_o),
    .raddr_b_i(id_rs2_o),
    .rdata_a_o(rf_a),
    .rdata_b_o(rf_b),
    .waddr_i  (wb_addr_i),
    .wdata_i  (wb_data_i),
    .we_i     (wb_we_i)
  );

  ////////////////////
  // Control decode
  ////////////////////

  // SUB only exists as a register op
  always_comb begin
    case (funct3)
      3'b000: arith_op = (opcode == OPC_OP && instr_i[30]) ? ALU_SUB : ALU_ADD;
      3'b001: arith_op = ALU_SLL;
      3'b010: arith_op = ALU_SLT;
      3'b011: arith_op = ALU_SLTU;
      3'b100: arith_op = ALU_XOR;
      3'b101: arith_op = instr_i[30] ? ALU_SRA : ALU_SRL;
      3'b110: arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl         = '0;
    ctrl.alu_op  = ALU_ADD;
    ctrl.wb_sel  = WB_ALU;
    imm_sel      = IMM_I;
    case (opcode)
      OPC_OP: begin
        ctrl.reg_we = 1'b1;
        ctrl.alu_op = arith_op;
      end
      OPC_OP_IMM: begin
        ctrl.reg_we    = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.alu_op    = arith_op;
      end
      OPC_LUI, OPC_AUIPC: begin
        ctrl.reg_we    = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.a_sel_pc  = (opcode == OPC_AUIPC);
        ctrl.alu_op    = (opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
        imm_sel        = IMM_U;
      end
      OPC_JAL: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = WB_PC4;
        imm_sel     = IMM_J;
      end
      OPC_JALR: begin
        ctrl.reg_we    = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.wb_sel    = WB_PC4;
      end
      OPC_BRANCH: begin
        ctrl.a_sel_pc  = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.is_branch = 1'b1;
        imm_sel        = IMM_B;
      end
      OPC_LOAD: begin
        ctrl.reg_we    = 1'b1;
        ctrl.b_sel_imm = 1'b1;
        ctrl.wb_sel    = WB_MEM;
      end
      OPC_STORE: begin
        ctrl.b_sel_imm = 1'b1;
        ctrl.mem_we    = 1'b1;
        imm_sel        = IMM_S;
      end
      // Only CSRRW and CSRRWI
      OPC_SYSTEM: ctrl.is_csr = (funct3[1:0] == 2'b01);
      default: ctrl = '0;
    endcase
  end

  always_comb begin
    case (imm_sel)
      IMM_S: imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      IMM_B: imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
      IMM_U: imm = {instr_i[31:12], 12'b0};
      IMM_J: imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
      default: imm = {{20{instr_i[31]}}, instr_i[31:20]};
    endcase
  end

  // JAL resolves here
  assign jal_o        = (opcode == OPC_JAL);
  assign jal_target_o = pc_i + imm;

  // Operand forwarding
  assign op_a = (fwd_a_sel_i == 2'd1) ? exe_result_i :
                (fwd_a_sel_i == 2'd2) ? wb_data_i    : rf_a;
  assign op_b = (fwd_b_sel_i == 2'd1) ? exe_result_i :
                (fwd_b_sel_i == 2'd2) ? wb_data_i    : rf_b;

  ////////////////////
  // Into execute
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst_i || kill_i) begin
      ctrl_o <= '0;
    end else begin
      ctrl_o <= ctrl;
    end
  end

  always_ff @(posedge clk) begin
    rs1_val_o <= op_a;
    rs2_val_o <= op_b;
    imm_o     <= imm;
    pc_o      <= pc_i;
    funct_o   <= {funct3, instr_i[19:15]};
    rd_o      <= instr_i[11:7];
    rs1_o     <= id_rs1_o;
    rs2_o     <= id_rs2_o;
  end

endmodule

`default_nettype wire

//--- fetch/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
  parameter logic [riscv_pkg::XLEN-1:0] PC_RESET = 32'h0000_2000
) (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       jal_i,
  input  logic [riscv_pkg::XLEN-1:0] jal_target_i,
  input  logic                       redirect_i,
  input  logic [riscv_pkg::XLEN-1:0] redirect_target_i,
  output logic [riscv_pkg::XLEN-1:0] icache_addr_o,
  input  logic [riscv_pkg::XLEN-1:0] icache_dout_i,
  output logic [riscv_pkg::XLEN-1:0] instr_o,
  output logic [riscv_pkg::XLEN-1:0] pc_o
);
  import riscv_pkg::*;

  logic [XLEN-1:0] pc_q, pc_next;
  logic            bubble_q;

  // Execute redirect wins over JAL
  assign pc_next = redirect_i ? redirect_target_i :
                   jal_i      ? jal_target_i      : pc_q + 32'd4;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q     <= PC_RESET;
      bubble_q <= 1'b1;
    end else begin
      pc_q     <= pc_next;
      bubble_q <= jal_i || redirect_i;
    end
  end

  // PC of the word now arriving from memory
  always_ff @(posedge clk) begin
    pc_o <= pc_q;
  end

  assign icache_addr_o = pc_q;
  assign instr_o       = bubble_q ? NOP_INSTR : icache_dout_i;

endmodule

`default_nettype wire

//--- decode/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic [riscv_pkg::REG_AW-1:0] raddr_a_i,
  input  logic [riscv_pkg::REG_AW-1:0] raddr_b_i,
  output logic [riscv_pkg::XLEN-1:0]   rdata_a_o,
  output logic [riscv_pkg::XLEN-1:0]   rdata_b_o,
  input  logic [riscv_pkg::REG_AW-1:0] waddr_i,
  input  logic [riscv_pkg::XLEN-1:0]   wdata_i,
  input  logic                         we_i
);
  import riscv_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (we_i && !rst_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

//--- execute/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  logic [riscv_pkg::XLEN-1:0] a_i,
  input  logic [riscv_pkg::XLEN-1:0] b_i,
  input  riscv_pkg::alu_op_e         op_i,
  output logic [riscv_pkg::XLEN-1:0] result_o
);
  import riscv_pkg::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, a_i < b_i};
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_OR:     result_o = a_i | b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- common/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  // Major opcodes kept by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // Register write source
  typedef enum logic [1:0] {
    WB_MEM,
    WB_ALU,
    WB_PC4
  } wb_sel_e;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_sel_e;

  // All zero is a bubble
  typedef struct packed {
    logic    reg_we;
    logic    a_sel_pc;
    logic    b_sel_imm;
    alu_op_e alu_op;
    logic    mem_we;
    logic    is_branch;
    logic    is_jalr;
    logic    is_csr;
    wb_sel_e wb_sel;
  } ctrl_t;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire
